// File: hv_geom_pkg.sv
`default_nettype none

package hv_geom_pkg;

    // one bit per dimension of a bipolar hypervector
    localparam int HV_DIM = 32;

    // encoder cores delivering one vector each per batch
    localparam int NUM_CORES = 32;

    // core index and remainder width
    // NUM_CORES is a power of two, so the remainder is the low bits of a count
    localparam int CORE_IDX_W = $clog2(NUM_CORES);

endpackage

`default_nettype wire

// File: vote_pkg.sv
`default_nettype none

package vote_pkg;

    // largest bundle the sequencer accepts
    localparam int MAX_VECTORS = 255;

    // vector count width at the start interface
    localparam int VEC_CNT_W = $clog2(MAX_VECTORS + 1);

    // signed vote counter, holds +/-MAX_VECTORS with a bit to spare
    localparam int CNT_W = VEC_CNT_W + 2;

    // tie-break LFSR reset state and Galois feedback taps
    localparam logic [31:0] LFSR_SEED = 32'hACE1_2024;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

endpackage

`default_nettype wire

// File: bit_vote_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_vote_counter (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              update,
    input  logic                              first_batch,
    input  logic                              tie_bit,
    input  logic [hv_geom_pkg::NUM_CORES-1:0] ignore,
    input  logic [hv_geom_pkg::NUM_CORES-1:0] votes,
    output logic                              sign_bit
);

    logic signed [vote_pkg::CNT_W-1:0] batch_sum;
    logic signed [vote_pkg::CNT_W-1:0] count;

    // +1 for a one, -1 for a zero, masked cores skipped
    always_comb begin
        batch_sum = '0;
        for (int k = 0; k < hv_geom_pkg::NUM_CORES; k++) begin
            if (!ignore[k]) begin
                batch_sum = batch_sum + (votes[k]
                    ? $signed({{(vote_pkg::CNT_W-1){1'b0}}, 1'b1})
                    : $signed({vote_pkg::CNT_W{1'b1}}));
            end
        end
    end

    // first batch reloads, so nothing carries over between bundles
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (update) begin
            if (first_batch) begin
                count <= batch_sum;
            end else begin
                count <= count + batch_sum;
            end
        end
    end

    // positive -> 1, negative -> 0, zero falls back to the lfsr bit
    assign sign_bit = (count == '0) ? tie_bit : ~count[vote_pkg::CNT_W-1];

endmodule

`default_nettype wire

// File: tie_break_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module tie_break_lfsr (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           step,
    output logic [hv_geom_pkg::HV_DIM-1:0] tie_bits
);

    // galois form, shift right and fold taps in on a shifted-out one
    always_ff @(posedge clk) begin
        if (reset) begin
            tie_bits <= vote_pkg::LFSR_SEED;
        end else if (step) begin
            tie_bits <= {1'b0, tie_bits[hv_geom_pkg::HV_DIM-1:1]}
                      ^ ({hv_geom_pkg::HV_DIM{tie_bits[0]}} & vote_pkg::LFSR_TAPS);
        end
    end

    // held between steps so every dimension sees one bit for the whole bundle

endmodule

`default_nettype wire

// File: bundle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_sequencer (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  logic [vote_pkg::VEC_CNT_W-1:0]     vec_count,
    input  logic                               batch_valid,
    output logic                               busy,
    output logic                               update,
    output logic                               first_batch,
    output logic                               last_update,
    output logic                               get_fin,
    output logic                               stream_v,
    output logic [hv_geom_pkg::CORE_IDX_W-1:0] remainder
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RUN,
        S_GET,
        S_STREAM,
        S_DONE
    } seq_state_t;

    seq_state_t state;

    // batches still expected, at most ceil(MAX_VECTORS / NUM_CORES)
    logic [vote_pkg::VEC_CNT_W-hv_geom_pkg::CORE_IDX_W:0] batches_left;
    logic [vote_pkg::VEC_CNT_W:0]                         rounded_count;
    logic                                                 first_q;

    // vec_count + NUM_CORES - 1, upper bits give the batch total
    assign rounded_count = {1'b0, vec_count}
                         + {{(vote_pkg::VEC_CNT_W+1-hv_geom_pkg::CORE_IDX_W){1'b0}},
                            {hv_geom_pkg::CORE_IDX_W{1'b1}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            batches_left <= '0;
            remainder    <= '0;
            first_q      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // an empty bundle has nothing to vote on
                    if (start && vec_count != '0) begin
                        state        <= S_RUN;
                        batches_left <= rounded_count[vote_pkg::VEC_CNT_W:hv_geom_pkg::CORE_IDX_W];
                        remainder    <= vec_count[hv_geom_pkg::CORE_IDX_W-1:0];
                        first_q      <= 1'b1;
                    end
                end
                S_RUN: begin
                    if (update) begin
                        first_q      <= 1'b0;
                        batches_left <= batches_left - 1'b1;
                        if (last_update) begin
                            state <= S_GET;
                        end
                    end
                end
                S_GET:    state <= S_STREAM;
                S_STREAM: state <= S_DONE;
                // result cycle, busy drops with hv_valid
                S_DONE:   state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // batch strobe only counts while collecting
    assign update      = batch_valid && (state == S_RUN);
    assign first_batch = first_q && (state == S_RUN);
    assign last_update = (state == S_RUN) && (batches_left == 1);
    assign get_fin     = (state == S_GET);
    assign stream_v    = (state == S_STREAM);
    assign busy        = (state != S_IDLE);

endmodule

`default_nettype wire

// File: buffer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_ctrl (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                update,
    input  logic                                                first_batch,
    input  logic                                                last_update,
    input  logic                                                stream_v,
    input  logic [hv_geom_pkg::CORE_IDX_W-1:0]                  remainder,
    input  logic [hv_geom_pkg::HV_DIM-1:0]                      tie_bits,
    input  logic [hv_geom_pkg::NUM_CORES*hv_geom_pkg::HV_DIM-1:0] core_slices,
    output logic [hv_geom_pkg::HV_DIM-1:0]                      hv,
    output logic                                                hv_valid
);

    logic [hv_geom_pkg::NUM_CORES-1:0] ignore;
    logic [hv_geom_pkg::NUM_CORES-1:0] dim_votes [hv_geom_pkg::HV_DIM];
    logic [hv_geom_pkg::HV_DIM-1:0]    sign_bits;

    // set bit = core ignored, only on a partial final batch
    always_comb begin
        ignore = '0;
        if (last_update && remainder != '0) begin
            for (int k = 0; k < hv_geom_pkg::NUM_CORES; k++) begin
                ignore[k] = (k >= int'(remainder));
            end
        end
    end

    // counter d gets bit d of every core
    always_comb begin
        for (int d = 0; d < hv_geom_pkg::HV_DIM; d++) begin
            for (int k = 0; k < hv_geom_pkg::NUM_CORES; k++) begin
                dim_votes[d][k] = core_slices[k*hv_geom_pkg::HV_DIM + d];
            end
        end
    end

    for (genvar d = 0; d < hv_geom_pkg::HV_DIM; d++) begin : g_dim
        bit_vote_counter u_counter (
            .clk         (clk),
            .reset       (reset),
            .update      (update),
            .first_batch (first_batch),
            .tie_bit     (tie_bits[d]),
            .ignore      (ignore),
            .votes       (dim_votes[d]),
            .sign_bit    (sign_bits[d])
        );
    end

    // update -> get_fin -> stream_v, signs have settled by stream_v
    always_ff @(posedge clk) begin
        if (reset) begin
            hv       <= '0;
            hv_valid <= 1'b0;
        end else begin
            hv_valid <= stream_v;
            if (stream_v) begin
                hv <= sign_bits;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdc_bundler_top.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_top (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                start,
    input  logic [vote_pkg::VEC_CNT_W-1:0]                      vec_count,
    input  logic                                                batch_valid,
    input  logic [hv_geom_pkg::NUM_CORES*hv_geom_pkg::HV_DIM-1:0] core_slices,
    output logic [hv_geom_pkg::HV_DIM-1:0]                      hv,
    output logic                                                hv_valid,
    output logic                                                busy
);

    logic                               update;
    logic                               first_batch;
    logic                               last_update;
    logic                               get_fin;
    logic                               stream_v;
    logic [hv_geom_pkg::CORE_IDX_W-1:0] remainder;
    logic [hv_geom_pkg::HV_DIM-1:0]     tie_bits;

    bundle_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .vec_count   (vec_count),
        .batch_valid (batch_valid),
        .busy        (busy),
        .update      (update),
        .first_batch (first_batch),
        .last_update (last_update),
        .get_fin     (get_fin),
        .stream_v    (stream_v),
        .remainder   (remainder)
    );

    // one step per bundle, taken with its first batch
    tie_break_lfsr u_lfsr (
        .clk      (clk),
        .reset    (reset),
        .step     (update && first_batch),
        .tie_bits (tie_bits)
    );

    buffer_ctrl u_buf (
        .clk         (clk),
        .reset       (reset),
        .update      (update),
        .first_batch (first_batch),
        .last_update (last_update),
        .stream_v    (stream_v),
        .remainder   (remainder),
        .tie_bits    (tie_bits),
        .core_slices (core_slices),
        .hv          (hv),
        .hv_valid    (hv_valid)
    );

endmodule

`default_nettype wire

// File: hdc_bundler_sva.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_sva (
    input logic clk,
    input logic reset,
    input logic update,
    input logic last_update,
    input logic get_fin,
    input logic stream_v,
    input logic hv_valid,
    input logic busy
);

    // violation count
    int fail_count = 0;

    // result is a one-cycle pulse
    a_hv_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        hv_valid |=> !hv_valid)
        else begin fail_count++; $error("hv_valid wider than one cycle"); end

    // final update -> get_fin -> stream_v -> hv_valid
    a_finish_seq: assert property (@(posedge clk) disable iff (reset)
        (update && last_update) |-> ##1 get_fin ##1 stream_v ##1 hv_valid)
        else begin fail_count++; $error("finish sequence out of order"); end

    a_no_early_result: assert property (@(posedge clk) disable iff (reset)
        hv_valid |-> $past(update && last_update, 3))
        else begin fail_count++; $error("hv_valid without a final update"); end

    // busy drops together with the result pulse
    a_busy_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $fell(hv_valid))
        else begin fail_count++; $error("busy fell apart from hv_valid"); end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !(update || get_fin || stream_v || hv_valid || busy))
        else begin fail_count++; $error("strobe active right after reset"); end

endmodule

bind hdc_bundler_top hdc_bundler_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .update      (update),
    .last_update (last_update),
    .get_fin     (get_fin),
    .stream_v    (stream_v),
    .hv_valid    (hv_valid),
    .busy        (busy)
);

`default_nettype wire

// File: hdc_bundler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_tb;

    localparam int DIM = hv_geom_pkg::HV_DIM;
    localparam int CORES = hv_geom_pkg::NUM_CORES;
    localparam int TIMEOUT = 200;
    localparam logic [DIM-1:0] ONES = '1;

    logic                          clk;
    logic                          reset;
    logic                          start;
    logic [vote_pkg::VEC_CNT_W-1:0] vec_count;
    logic                          batch_valid;
    logic [CORES*DIM-1:0]          core_slices;
    logic [DIM-1:0]                hv;
    logic                          hv_valid;
    logic                          busy;

    // reference model state
    logic [DIM-1:0] lfsr_model;
    int             counts [DIM];

    hdc_bundler_top uut (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .vec_count   (vec_count),
        .batch_valid (batch_valid),
        .core_slices (core_slices),
        .hv          (hv),
        .hv_valid    (hv_valid),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // galois step shifts right and folds the taps in on a shifted-out one
    function automatic logic [DIM-1:0] next_lfsr(logic [DIM-1:0] s);
        return (s >> 1) ^ (s[0] ? vote_pkg::LFSR_TAPS : '0);
    endfunction

    function automatic logic [DIM-1:0] model_result();
        logic [DIM-1:0] r;
        for (int d = 0; d < DIM; d++) begin
            if (counts[d] > 0) begin
                r[d] = 1'b1;
            end else if (counts[d] < 0) begin
                r[d] = 1'b0;
            end else begin
                r[d] = lfsr_model[d];
            end
        end
        return r;
    endfunction

    // 0 ones, 1 zeros, 3 partial lean-to-zero, 4 complement pair, else random
    function automatic logic [DIM-1:0] core_word(int pattern, int b, int k,
                                                 logic [DIM-1:0] pair);
        logic [DIM-1:0] w;
        case (pattern)
            0: w = ONES;
            1: w = '0;
            3: begin
                if (b == 0) begin
                    w = (k < 16) ? ONES : '0;
                end else begin
                    w = (k < 8) ? '0 : ONES;
                end
            end
            4: w = (k == 0) ? pair : ((k == 1) ? ~pair : $urandom());
            default: w = $urandom();
        endcase
        return w;
    endfunction

    task automatic check_hv(string name, logic [DIM-1:0] expected);
        assert (hv === expected) else
            fail_now($sformatf("FAILED %s: expected %h, actual %h", name, expected, hv));
        assert (uut.u_sva.fail_count == 0) else
            fail_now("a bound assertion on the DUT strobes was violated");
    endtask

    // optional noise on start and batch_valid during the finish cycles
    task automatic wait_result(string name, bit noise);
        int cycles;
        cycles = 0;
        while (!hv_valid) begin
            start       = noise;
            batch_valid = noise;
            vec_count   = vote_pkg::VEC_CNT_W'($urandom);
            core_slices = {CORES{ONES}};
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_now($sformatf("timeout waiting for hv_valid in %s", name));
            end
            @(negedge clk);
        end
        start       = 1'b0;
        batch_valid = 1'b0;
        check_hv(name, model_result());
    endtask

    task automatic run_bundle(string name, int n, int pattern, bit noise);
        int             batches;
        int             valid;
        int             cycles;
        logic [DIM-1:0] pair;
        logic [DIM-1:0] w;
        batches = (n + CORES - 1) / CORES;
        pair = $urandom();
        cycles = 0;
        @(negedge clk);
        start = 1'b1;
        vec_count = vote_pkg::VEC_CNT_W'(n);
        @(negedge clk);
        start = 1'b0;
        while (!busy) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_now($sformatf("busy never rose after start in %s", name));
            end
            @(negedge clk);
        end
        // counters reload and the lfsr steps once per bundle
        lfsr_model = next_lfsr(lfsr_model);
        for (int d = 0; d < DIM; d++) begin
            counts[d] = 0;
        end
        for (int b = 0; b < batches; b++) begin
            valid = (b == batches - 1 && n % CORES != 0) ? n % CORES : CORES;
            for (int k = 0; k < CORES; k++) begin
                w = core_word(pattern, b, k, pair);
                core_slices[k*DIM +: DIM] = w;
                if (k < valid) begin
                    for (int d = 0; d < DIM; d++) begin
                        counts[d] += w[d] ? 1 : -1;
                    end
                end
            end
            batch_valid = 1'b1;
            @(negedge clk);
            batch_valid = 1'b0;
            // stray start between batches
            if (noise && b < batches - 1) begin
                start = 1'b1;
                vec_count = vote_pkg::VEC_CNT_W'($urandom);
                @(negedge clk);
                start = 1'b0;
            end
        end
        wait_result(name, noise);
    endtask

    initial begin
        void'($urandom(32'h3234));
        reset       = 1'b1;
        start       = 1'b0;
        vec_count   = '0;
        batch_valid = 1'b0;
        core_slices = '0;
        lfsr_model  = vote_pkg::LFSR_SEED;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!hv_valid && !busy && hv == '0) else
            fail_now("outputs were not idle after reset");

        run_bundle("unanimous_ones", 64, 0, 1'b0);
        run_bundle("unanimous_zeros", 64, 1, 1'b0);
        for (int i = 0; i < 6; i++) begin
            run_bundle($sformatf("random_majority_%0d", i), 33 + $urandom % 223, 2, 1'b0);
        end
        run_bundle("partial_last", 40, 3, 1'b0);
        run_bundle("ties", 2, 4, 1'b0);

        // a batch while idle must not touch the counters
        @(negedge clk);
        batch_valid = 1'b1;
        core_slices = {CORES{ONES}};
        @(negedge clk);
        batch_valid = 1'b0;
        for (int i = 0; i < 4; i++) begin
            run_bundle($sformatf("back_to_back_%0d", i), 1 + $urandom % 255, 2, 1'b1);
        end
        run_bundle("back_to_back_single", 1, 2, 1'b1);

        if (uut.u_sva.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_now("a bound assertion on the DUT strobes was violated");
        end
    end

endmodule

`default_nettype wire

// File: hdc_bundler_top.f
hv_geom_pkg.sv
vote_pkg.sv
bit_vote_counter.sv
tie_break_lfsr.sv
bundle_sequencer.sv
buffer_ctrl.sv
hdc_bundler_top.sv
hdc_bundler_sva.sv
hdc_bundler_tb.sv

// File: Makefile
SIM        = verilator
TOP        = hdc_bundler_tb
FILELIST   = hdc_bundler_top.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS = --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
